// ==== rtl/sudoku_consts.svh ====
`ifndef SUDOKU_CONSTS_SVH
`define SUDOKU_CONSTS_SVH

// ==================================================
// Grid geometry
// ==================================================

// Side of the grid, of one house and of the digit range
`define SUDOKU_DIM 9
// Side of one block
`define SUDOKU_BOX 3
`define SUDOKU_CELLS 81

// ==================================================
// Widths
// ==================================================
`define SUDOKU_DIGIT_W 4
// Needs to hold 81 as the past-the-end index
`define SUDOKU_IDX_W 7
`define SUDOKU_MEM_W 8

`endif

// ==== rtl/sudoku_grid_pkg.sv ====
`include "sudoku_consts.svh"

package sudoku_grid_pkg;

    // ==================================================
    // Puzzle contents
    // ==================================================

    // Cell value, zero for an empty cell
    typedef logic [`SUDOKU_DIGIT_W-1:0] digit_t;

    // Row-major index, 81 means past the last cell
    typedef logic [`SUDOKU_IDX_W-1:0] cell_idx_t;

    // One row, column or block, element 0 first
    typedef digit_t [`SUDOKU_DIM-1:0] house_t;

    // Bit n set when cell n holds a given
    typedef logic [`SUDOKU_CELLS-1:0] fixed_map_t;

endpackage

// ==== rtl/sudoku_ctrl_pkg.sv ====
`include "sudoku_consts.svh"

package sudoku_ctrl_pkg;

    // Top level sequencing
    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        SOLVE,
        WRITE_OUT
    } solver_state_t;

    // ROM and RAM port words
    typedef logic [`SUDOKU_IDX_W-1:0] mem_addr_t;
    typedef logic [`SUDOKU_MEM_W-1:0] mem_word_t;

endpackage

// ==== rtl/grid_store.sv ====
`include "sudoku_consts.svh"

module grid_store
    import sudoku_grid_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  cell_idx_t  cursor_i,
    input  logic       load_en_i,
    input  digit_t     load_digit_i,
    input  logic       load_fixed_i,
    input  logic       solve_wr_i,
    input  digit_t     solve_digit_i,
    output digit_t     cur_digit_o,
    output logic       cur_fixed_o,
    output fixed_map_t fixed_map_o,
    output house_t     row_o,
    output house_t     col_o,
    output house_t     blk_o
);

    digit_t     cells [`SUDOKU_CELLS];
    fixed_map_t fixed_q;

    cell_idx_t  cell_sel;
    logic [3:0] row_sel;
    logic [3:0] col_sel;
    logic [3:0] blk_sel;

    house_t     row_bus [`SUDOKU_DIM];
    house_t     col_bus [`SUDOKU_DIM];
    house_t     blk_bus [`SUDOKU_DIM];

    // ==================================================
    // Coordinates of the current cell
    // ==================================================

    // Past-the-end cursor aliases cell 0
    assign cell_sel = (cursor_i < `SUDOKU_IDX_W'(`SUDOKU_CELLS)) ? cursor_i : '0;

    assign row_sel = 4'(cell_sel / `SUDOKU_DIM);
    assign col_sel = 4'(cell_sel % `SUDOKU_DIM);
    assign blk_sel = 4'((row_sel / `SUDOKU_BOX) * `SUDOKU_BOX + col_sel / `SUDOKU_BOX);

    // ==================================================
    // Storage
    // ==================================================

    // Load has priority, the FSM never raises both
    always_ff @(posedge clk) begin
        if (load_en_i) begin
            cells[cell_sel] <= load_digit_i;
        end else if (solve_wr_i) begin
            cells[cell_sel] <= solve_digit_i;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fixed_q <= '0;
        end else if (load_en_i) begin
            fixed_q[cell_sel] <= load_fixed_i;
        end
    end

    // ==================================================
    // House buses
    // ==================================================
    always_comb begin
        for (int r = 0; r < `SUDOKU_DIM; r++) begin
            for (int c = 0; c < `SUDOKU_DIM; c++) begin
                row_bus[r][c] = cells[r * `SUDOKU_DIM + c];
                col_bus[c][r] = cells[r * `SUDOKU_DIM + c];
                // Block number, then position inside the block
                blk_bus[(r / `SUDOKU_BOX) * `SUDOKU_BOX + c / `SUDOKU_BOX]
                       [(r % `SUDOKU_BOX) * `SUDOKU_BOX + c % `SUDOKU_BOX] =
                    cells[r * `SUDOKU_DIM + c];
            end
        end
    end

    assign row_o = row_bus[row_sel];
    assign col_o = col_bus[col_sel];
    assign blk_o = blk_bus[blk_sel];

    assign cur_digit_o = cells[cell_sel];
    assign cur_fixed_o = fixed_q[cell_sel];
    assign fixed_map_o = fixed_q;

endmodule

// ==== rtl/candidate_picker.sv ====
`include "sudoku_consts.svh"

module candidate_picker
    import sudoku_grid_pkg::*;
(
    input  digit_t cur_digit_i,
    input  house_t row_i,
    input  house_t col_i,
    input  house_t blk_i,
    output digit_t cand_digit_o,
    output logic   backtrack_o
);

    logic [`SUDOKU_DIM:1] used_mask;
    logic [`SUDOKU_DIM:1] above_mask;
    logic [`SUDOKU_DIM:1] avail_mask;

    // Digits already present in any of the three houses
    always_comb begin
        used_mask = '0;
        for (int d = 1; d <= `SUDOKU_DIM; d++) begin
            for (int i = 0; i < `SUDOKU_DIM; i++) begin
                if (row_i[i] == digit_t'(d) || col_i[i] == digit_t'(d) ||
                    blk_i[i] == digit_t'(d)) begin
                    used_mask[d] = 1'b1;
                end
            end
        end
    end

    // Only values above the present one keep the search ordered
    always_comb begin
        for (int d = 1; d <= `SUDOKU_DIM; d++) begin
            above_mask[d] = (digit_t'(d) > cur_digit_i);
        end
    end

    assign avail_mask = ~used_mask & above_mask;

    // Priority encoder, lowest digit wins
    always_comb begin
        cand_digit_o = '0;
        for (int d = `SUDOKU_DIM; d >= 1; d--) begin
            if (avail_mask[d]) begin
                cand_digit_o = digit_t'(d);
            end
        end
    end

    // Nothing left means the cell is exhausted
    assign backtrack_o = ~|avail_mask;

endmodule

// ==== rtl/cell_cursor.sv ====
`include "sudoku_consts.svh"

module cell_cursor
    import sudoku_grid_pkg::*;
(
    input  fixed_map_t fixed_map_i,
    input  cell_idx_t  cursor_i,
    output cell_idx_t  next_idx_o,
    output cell_idx_t  prev_idx_o
);

    // ==================================================
    // Forward search
    // ==================================================

    // Scan downwards so the lowest match is written last
    always_comb begin
        next_idx_o = cell_idx_t'(`SUDOKU_CELLS);
        for (int i = `SUDOKU_CELLS - 1; i >= 0; i--) begin
            if (cell_idx_t'(i) > cursor_i && !fixed_map_i[i]) begin
                next_idx_o = cell_idx_t'(i);
            end
        end
    end

    // ==================================================
    // Backward search
    // ==================================================

    // Falls back to cell 0 when no empty cell lies below
    always_comb begin
        prev_idx_o = '0;
        for (int i = 0; i < `SUDOKU_CELLS; i++) begin
            if (cell_idx_t'(i) < cursor_i && !fixed_map_i[i]) begin
                prev_idx_o = cell_idx_t'(i);
            end
        end
    end

endmodule

// ==== rtl/solver_fsm.sv ====
`include "sudoku_consts.svh"

module solver_fsm
    import sudoku_grid_pkg::*, sudoku_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  mem_word_t rom_data_i,
    input  logic      cur_fixed_i,
    input  digit_t    cand_digit_i,
    input  logic      backtrack_i,
    input  cell_idx_t next_idx_i,
    input  cell_idx_t prev_idx_i,
    output cell_idx_t cursor_o,
    output logic      load_en_o,
    output digit_t    load_digit_o,
    output logic      load_fixed_o,
    output logic      solve_wr_o,
    output digit_t    solve_digit_o,
    output logic      rom_rd_o,
    output logic      ram_ce_o,
    output logic      ram_we_n_o,
    output logic      done_o
);

    localparam cell_idx_t last_idx = cell_idx_t'(`SUDOKU_CELLS - 1);
    localparam cell_idx_t end_idx  = cell_idx_t'(`SUDOKU_CELLS);

    solver_state_t state_q;
    cell_idx_t     cursor_q;
    logic          in_grid;

    assign in_grid = (cursor_q != end_idx);

    // ==================================================
    // Sequencing
    // ==================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q  <= IDLE;
            cursor_q <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    state_q  <= LOAD;
                    cursor_q <= '0;
                end
                LOAD: begin
                    if (cursor_q == last_idx) begin
                        state_q  <= SOLVE;
                        cursor_q <= '0;
                    end else begin
                        cursor_q <= cursor_q + 1'b1;
                    end
                end
                SOLVE: begin
                    if (!in_grid) begin
                        state_q  <= WRITE_OUT;
                        cursor_q <= '0;
                    end else if (!cur_fixed_i && backtrack_i) begin
                        cursor_q <= prev_idx_i;
                    end else begin
                        // Skip a given or advance after placing a digit
                        cursor_q <= next_idx_i;
                    end
                end
                WRITE_OUT: begin
                    // Parks at the end index, which holds done
                    if (in_grid) begin
                        cursor_q <= cursor_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // ==================================================
    // Grid store controls
    // ==================================================
    assign cursor_o     = cursor_q;
    assign load_en_o    = (state_q == LOAD);
    assign load_digit_o = rom_data_i[`SUDOKU_DIGIT_W-1:0];
    // Any non-zero word is a given
    assign load_fixed_o = |rom_data_i;

    assign solve_wr_o    = (state_q == SOLVE) && in_grid && !cur_fixed_i;
    // Exhausted cell goes back to empty
    assign solve_digit_o = backtrack_i ? '0 : cand_digit_i;

    // Memory ports
    assign rom_rd_o   = (state_q == LOAD);
    assign ram_ce_o   = (state_q == WRITE_OUT) && in_grid;
    assign ram_we_n_o = !ram_ce_o;
    assign done_o     = (state_q == WRITE_OUT) && !in_grid;

endmodule

// ==== rtl/sudoku_top.sv ====
`include "sudoku_consts.svh"

module sudoku_top
    import sudoku_grid_pkg::*, sudoku_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    output logic      rom_rd_o,
    output mem_addr_t rom_addr_o,
    input  mem_word_t rom_data_i,
    output logic      ram_ce_o,
    output logic      ram_we_n_o,
    output mem_addr_t ram_addr_o,
    output mem_word_t ram_data_o,
    output logic      done_o
);

    cell_idx_t  cursor;
    logic       load_en;
    digit_t     load_digit;
    logic       load_fixed;
    logic       solve_wr;
    digit_t     solve_digit;
    digit_t     cur_digit;
    logic       cur_fixed;
    fixed_map_t fixed_map;
    house_t     row;
    house_t     col;
    house_t     blk;
    digit_t     cand_digit;
    logic       backtrack;
    cell_idx_t  next_idx;
    cell_idx_t  prev_idx;

    solver_fsm solver_fsm_inst (
        .clk           (clk),
        .rst           (rst),
        .rom_data_i    (rom_data_i),
        .cur_fixed_i   (cur_fixed),
        .cand_digit_i  (cand_digit),
        .backtrack_i   (backtrack),
        .next_idx_i    (next_idx),
        .prev_idx_i    (prev_idx),
        .cursor_o      (cursor),
        .load_en_o     (load_en),
        .load_digit_o  (load_digit),
        .load_fixed_o  (load_fixed),
        .solve_wr_o    (solve_wr),
        .solve_digit_o (solve_digit),
        .rom_rd_o      (rom_rd_o),
        .ram_ce_o      (ram_ce_o),
        .ram_we_n_o    (ram_we_n_o),
        .done_o        (done_o)
    );

    grid_store grid_store_inst (
        .clk           (clk),
        .rst           (rst),
        .cursor_i      (cursor),
        .load_en_i     (load_en),
        .load_digit_i  (load_digit),
        .load_fixed_i  (load_fixed),
        .solve_wr_i    (solve_wr),
        .solve_digit_i (solve_digit),
        .cur_digit_o   (cur_digit),
        .cur_fixed_o   (cur_fixed),
        .fixed_map_o   (fixed_map),
        .row_o         (row),
        .col_o         (col),
        .blk_o         (blk)
    );

    candidate_picker candidate_picker_inst (
        .cur_digit_i  (cur_digit),
        .row_i        (row),
        .col_i        (col),
        .blk_i        (blk),
        .cand_digit_o (cand_digit),
        .backtrack_o  (backtrack)
    );

    cell_cursor cell_cursor_inst (
        .fixed_map_i (fixed_map),
        .cursor_i    (cursor),
        .next_idx_o  (next_idx),
        .prev_idx_o  (prev_idx)
    );

    // Both memories are addressed by the cursor
    assign rom_addr_o = cursor;
    assign ram_addr_o = cursor;
    assign ram_data_o = {{(`SUDOKU_MEM_W - `SUDOKU_DIGIT_W){1'b0}}, cur_digit};

endmodule

// ==== tests/sudoku_asserts.sv ====
`include "sudoku_consts.svh"

module sudoku_asserts
    import sudoku_ctrl_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      rom_rd_i,
    input logic      ram_ce_i,
    input logic      ram_we_n_i,
    input mem_addr_t ram_addr_i,
    input logic      done_i
);
    timeunit 1ns;
    timeprecision 1ns;

    int unsigned fail_count = 0;

    // ==================================================
    // Memory ports
    // ==================================================
    we_needs_ce: assert property (@(posedge clk) disable iff (rst) !ram_we_n_i |-> ram_ce_i)
        else begin
            fail_count++;
            $error("RAM write strobe without chip enable");
        end

    // ROM reads and RAM writes belong to different phases
    rom_ram_apart: assert property (@(posedge clk) disable iff (rst) !(rom_rd_i && ram_ce_i))
        else begin
            fail_count++;
            $error("ROM read and RAM access in the same cycle");
        end

    ram_addr_range: assert property (@(posedge clk) disable iff (rst)
                                     ram_ce_i |-> ram_addr_i < mem_addr_t'(`SUDOKU_CELLS))
        else begin
            fail_count++;
            $error("RAM address past the last cell");
        end

    // Done holds until the next reset
    done_sticky: assert property (@(posedge clk) disable iff (rst) done_i |=> done_i)
        else begin
            fail_count++;
            $error("done_o dropped without reset");
        end

endmodule

bind sudoku_top sudoku_asserts sudoku_asserts_inst (
    .clk        (clk),
    .rst        (rst),
    .rom_rd_i   (rom_rd_o),
    .ram_ce_i   (ram_ce_o),
    .ram_we_n_i (ram_we_n_o),
    .ram_addr_i (ram_addr_o),
    .done_i     (done_o)
);

// ==== tests/sudoku_tb.sv ====
`include "sudoku_consts.svh"

module sudoku_tb
    import sudoku_grid_pkg::*, sudoku_ctrl_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ns;

    localparam int clk_period      = 40;
    localparam int num_tests       = 6;
    localparam int max_test_cycles = 300000;
    localparam int num_cells       = `SUDOKU_CELLS;

    // One hex nibble per cell with row 0 first
    typedef logic [0:8][35:0] grid_rows_t;

    localparam grid_rows_t classic_solution = {
        36'h534678912, 36'h672195348, 36'h198342567,
        36'h859761423, 36'h426853791, 36'h713924856,
        36'h961537284, 36'h287419635, 36'h345286179
    };
    localparam grid_rows_t classic_puzzle = {
        36'h530070000, 36'h600195000, 36'h098000060,
        36'h800060003, 36'h400803001, 36'h700020006,
        36'h060000280, 36'h000419005, 36'h000080079
    };
    // First grid reached when digits are tried in increasing order
    localparam grid_rows_t smallest_grid = {
        36'h123456789, 36'h456789123, 36'h789123456,
        36'h214365897, 36'h365897214, 36'h897214365,
        36'h531642978, 36'h642978531, 36'h978531642
    };

    logic      clk;
    logic      rst;
    logic      rom_rd;
    mem_addr_t rom_addr;
    mem_word_t rom_data;
    logic      ram_ce;
    logic      ram_we_n;
    mem_addr_t ram_addr;
    mem_word_t ram_data;
    logic      done;

    mem_word_t   rom_mem [num_cells];
    digit_t      ram_mem [num_cells];
    int          rom_count   = 0;
    int          write_count = 0;
    logic        done_seen   = 1'b0;
    int          checks      = 0;
    int          mismatches  = 0;
    int          failures    = 0;
    logic [15:0] lfsr_state  = 16'd61802;

    sudoku_top sudoku_top_inst (
        .clk        (clk),
        .rst        (rst),
        .rom_rd_o   (rom_rd),
        .rom_addr_o (rom_addr),
        .rom_data_i (rom_data),
        .ram_ce_o   (ram_ce),
        .ram_we_n_o (ram_we_n),
        .ram_addr_o (ram_addr),
        .ram_data_o (ram_data),
        .done_o     (done)
    );

    // Combinational ROM that answers in the same cycle
    assign rom_data = (rom_addr < mem_addr_t'(num_cells)) ? rom_mem[rom_addr] : '0;

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(num_tests * max_test_cycles * clk_period);
        $display("Watchdog expired before the tests completed");
        $display("SOME TESTS FAILED");
        $finish;
    end

    // ==================================================
    // Checks
    // ==================================================
    task automatic check_digit(input digit_t got, input digit_t exp, input string what);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input mem_addr_t got, input mem_addr_t exp, input string what);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            mismatches++;
            $display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // Port monitor sampled mid-cycle
    always @(negedge clk) begin
        if (rst) begin
            if (rom_rd || ram_ce || !ram_we_n || done) begin
                failures++;
                $display("A control output was active during reset at %0t ns", $time);
            end
            rom_count   = 0;
            write_count = 0;
            done_seen   = 1'b0;
            for (int i = 0; i < num_cells; i++) begin
                ram_mem[i] = '0;
            end
        end else begin
            if (rom_rd) begin
                check_addr(rom_addr, mem_addr_t'(rom_count), "ROM read address");
                rom_count++;
            end
            if (ram_ce && !ram_we_n) begin
                check_addr(ram_addr, mem_addr_t'(write_count), "RAM write address");
                check_digit(digit_t'(ram_data[7:4]), '0, "RAM data upper bits");
                if (ram_addr < mem_addr_t'(num_cells)) begin
                    ram_mem[ram_addr] = digit_t'(ram_data[3:0]);
                end
                write_count++;
            end
            if (done && !done_seen && write_count != num_cells) begin
                failures++;
                $display("done_o rose after only %0d RAM writes", write_count);
            end
            if (done_seen && !done) begin
                failures++;
                $display("done_o fell at %0t ns without a reset", $time);
            end
            if (done) begin
                done_seen = 1'b1;
            end
        end
    end

    // ==================================================
    // Helpers
    // ==================================================
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    function automatic digit_t cell_of(input grid_rows_t rows, input int idx);
        return rows[idx / 9][(8 - idx % 9) * 4 +: 4];
    endfunction

    task automatic load_rom(input grid_rows_t rows);
        for (int i = 0; i < num_cells; i++) begin
            rom_mem[i] = mem_word_t'(cell_of(rows, i));
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic wait_done(input string name);
        int cycles;
        cycles = 0;
        while (!done && cycles < max_test_cycles) begin
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            failures++;
            $display("%s: done_o did not rise within %0d cycles", name, max_test_cycles);
        end
    endtask

    task automatic run_puzzle(input string name);
        apply_reset();
        wait_done(name);
        // Idle cycles so the monitor sees done_o hold
        repeat (3) @(negedge clk);
        check_count(rom_count, num_cells, {name, " ROM reads"});
        check_count(write_count, num_cells, {name, " RAM writes"});
    endtask

    task automatic check_grid(input grid_rows_t exp, input string name);
        for (int i = 0; i < num_cells; i++) begin
            check_digit(ram_mem[i], cell_of(exp, i), $sformatf("%s cell %0d", name, i));
        end
    endtask

    // Every house holds 1 to 9 once and every given survives
    task automatic check_rules(input string name);
        logic [9:0] row_seen;
        logic [9:0] col_seen;
        logic [9:0] blk_seen;
        for (int h = 0; h < 9; h++) begin
            row_seen = '0;
            col_seen = '0;
            blk_seen = '0;
            for (int k = 0; k < 9; k++) begin
                row_seen[ram_mem[h * 9 + k]] = 1'b1;
                col_seen[ram_mem[k * 9 + h]] = 1'b1;
                blk_seen[ram_mem[(h / 3) * 27 + (k / 3) * 9 + (h % 3) * 3 + k % 3]] = 1'b1;
            end
            checks++;
            if (row_seen != 10'h3fe || col_seen != 10'h3fe || blk_seen != 10'h3fe) begin
                failures++;
                $display("%s: row, column or block %0d lacks some digit", name, h);
            end
        end
        for (int i = 0; i < num_cells; i++) begin
            if (rom_mem[i] != '0) begin
                check_digit(ram_mem[i], digit_t'(rom_mem[i][3:0]),
                            $sformatf("%s given %0d", name, i));
            end
        end
    endtask

    // ==================================================
    // Directed tests
    // ==================================================
    task automatic test_full_grid();
        load_rom(classic_solution);
        run_puzzle("full grid");
        check_grid(classic_solution, "full grid");
    endtask

    task automatic test_one_blank();
        load_rom(classic_solution);
        rom_mem[40] = '0;
        run_puzzle("one blank");
        check_grid(classic_solution, "one blank");
    endtask

    task automatic test_classic();
        load_rom(classic_puzzle);
        run_puzzle("classic");
        check_grid(classic_solution, "classic");
    endtask

    task automatic test_empty_grid();
        load_rom('0);
        run_puzzle("empty grid");
        check_grid(smallest_grid, "empty grid");
    endtask

    task automatic test_random_blanks();
        logic [6:0] pick;
        int         blanked;
        load_rom(classic_solution);
        blanked = 0;
        for (int n = 0; n < 4000 && blanked < 40; n++) begin
            pick = '0;
            for (int b = 0; b < 7; b++) begin
                lfsr_state = lfsr_step(lfsr_state);
                pick = {pick[5:0], lfsr_state[0]};
            end
            if (pick < 7'(num_cells) && rom_mem[pick] != '0) begin
                rom_mem[pick] = '0;
                blanked++;
            end
        end
        run_puzzle("random blanks");
        check_rules("random blanks");
    endtask

    task automatic test_reset_in_solve();
        int n;
        load_rom(classic_puzzle);
        apply_reset();
        n = 0;
        while (!rom_rd && n < 200) begin
            @(negedge clk);
            n++;
        end
        while (rom_rd && n < 200) begin
            @(negedge clk);
            n++;
        end
        repeat (20) @(negedge clk);
        checks++;
        if (rom_rd || ram_ce || done) begin
            failures++;
            $display("Reset test: the search was not running when reset was applied");
        end
        run_puzzle("reset in solve");
        check_grid(classic_solution, "reset in solve");
    endtask

    initial begin
        int assert_fails;
        rst <= 1'b1;
        for (int i = 0; i < num_cells; i++) begin
            rom_mem[i] = '0;
        end
        test_full_grid();
        test_one_blank();
        test_classic();
        test_empty_grid();
        test_random_blanks();
        test_reset_in_solve();
        assert_fails = sudoku_top_inst.sudoku_asserts_inst.fail_count;
        $display("Checks %0d, mismatches %0d, other failures %0d, assertion failures %0d",
                 checks, mismatches, failures, assert_fails);
        if (mismatches == 0 && failures == 0 && assert_fails == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+rtl
rtl/sudoku_grid_pkg.sv
rtl/sudoku_ctrl_pkg.sv
rtl/grid_store.sv
rtl/candidate_picker.sv
rtl/cell_cursor.sv
rtl/solver_fsm.sv
rtl/sudoku_top.sv
tests/sudoku_asserts.sv
tests/sudoku_tb.sv

// ==== Makefile ====
TOP := sudoku_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "SOME TESTS FAILED" sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi

obj_dir/V$(TOP): files.f $(wildcard rtl/*.sv rtl/*.svh tests/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ns \
		-f files.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --assert -Wall --timescale 1ns/1ns \
		-f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
